// ==== tb.f ====
verilog/a2_bus_pkg.sv
verilog/a2_media_pkg.sv
verilog/signal_denoise.sv
verilog/reset_heartbeat.sv
verilog/bus_drive_arbiter.sv
verilog/audio_mixer.sv
verilog/qspi_status_streamer.sv
verilog/a2_card_top.sv
tb/tb_clock_gen.sv
tb/a2_card_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the card testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module a2_card_tb -f tb.f -o a2_card_sim
./obj_dir/a2_card_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== tb/a2_card_tb.sv ====
// Testbench for the card top level that drives random bus and audio traffic and checks each output
`timescale 1ns/1ps

module a2_card_tb;

    import a2_bus_pkg::*;
    import a2_media_pkg::*;

    typedef enum {MODE_NONE, MODE_ARB, MODE_BUSRST} check_mode_t;

    localparam int RESET_CYCLES = 16;
    localparam int HB_CYCLES = 40;
    localparam int SEND_LOG2 = 6;
    localparam int GLITCH_WATCH = 12;
    localparam int HOLD_SETTLE = 6;
    localparam int PHI_CYCLES = 2 * GLITCH_WATCH + 2 * (9 + HOLD_SETTLE);
    localparam int ARB_CYCLES = 200;
    localparam int MIX_CYCLES = 200;
    localparam int BUSRST_CYCLES = 40;
    localparam int TAIL_CYCLES = 160;
    localparam int MIN_FRAMES = 6;
    localparam int TEST_CYCLES = RESET_CYCLES + HB_CYCLES + 8 + PHI_CYCLES + ARB_CYCLES
                                 + MIX_CYCLES + BUSRST_CYCLES + TAIL_CYCLES + 4;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 50;

    logic clk_logic_w;
    logic rst_i, a2_reset_n_i, a2_phi1_i;
    a2_data_t a2_d_i, a2_d_o, ssc_data_i, ssp_data_i, mb_data_i;
    logic a2_d_dir_o, a2_irq_n_o;
    logic ssc_rd_i, ssp_rd_i, mb_rd_i, ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i;
    sample_t ssp_audio_i, audio_l_o, audio_r_o;
    mb_level_t mb_audio_l_i, mb_audio_r_i;
    logic speaker_i, led_n_o, parl_clk_o, parl_frame_n_o;
    nibble_t parl_d_o;

    check_mode_t mode = MODE_NONE;
    logic [31:0] lfsr_r = 32'hf7d5;
    int since_rel = 0, mismatches = 0, problems = 0;
    int last_start = 0, beats = 0, low_cycles = 0, frames_done = 0;
    logic in_frame = 1'b0, have_start = 1'b0, prev_clk = 1'b0, prev_frame_n = 1'b1;
    logic exp_led;
    logic [9:0] exp_bus;
    sample_t exp_l_q, exp_r_q;
    status_word_t frame_word;

    tb_clock_gen #(.PERIOD_NS(10)) u_clk (.clk_o(clk_logic_w));

    a2_card_top #(
        .HEARTBEAT_CYCLES(HB_CYCLES),
        .SEND_INTERVAL_LOG2(SEND_LOG2)
    ) u_dut (.*);

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s: expected %0h, actual %0h at %0t ns", name, exp, act, $time);
        mismatches++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s at %0t ns", msg, $time);
        problems++;
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
            lfsr_r = {lfsr_r[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Expected {dir, irq_n, data} where rd is {mb, ssp, ssc}
    function automatic logic [9:0] ref_bus(input logic phi0, input logic sys_rst,
                                           input logic [2:0] rd, input logic [2:0] irq_n,
                                           input a2_data_t ssc, input a2_data_t ssp,
                                           input a2_data_t mb, input a2_data_t bus);
        logic dir;
        logic irq;
        a2_data_t data;
        dir = phi0 && (rd != 3'b000) && BUS_DATA_OUT_ENABLE && !sys_rst;
        data = rd[0] ? ssc : (rd[1] ? ssp : (rd[2] ? mb : bus));
        irq = (sys_rst || !IRQ_OUT_ENABLE) ? 1'b1 : (irq_n == 3'b111);
        return {dir, irq, data};
    endfunction

    function automatic sample_t ref_mix(input sample_t ssp, input mb_level_t mb, input logic spk);
        int sum;
        sum = int'(ssp) + int'(mb) * (2 ** MB_SHIFT) + int'(spk) * (2 ** SPEAKER_SHIFT);
        return sample_t'(sum % 65536);
    endfunction

    // Nibble idx of a frame counted from the most significant end
    function automatic nibble_t ref_nibble(input int idx);
        status_word_t w;
        w = STATUS_WORD >> (4 * (NIBBLES_PER_WORD - 1 - idx));
        return w[3:0];
    endfunction

    task automatic drive_cards(input logic force_ssc);
        logic [31:0] r;
        r = rand_bits(6);
        ssc_rd_i <= r[0] | force_ssc;
        ssp_rd_i <= r[1];
        mb_rd_i <= r[2];
        ssc_irq_n_i <= r[3];
        ssp_irq_n_i <= r[4];
        mb_irq_n_i <= r[5];
        r = rand_bits(32);
        {ssc_data_i, ssp_data_i, mb_data_i, a2_d_i} <= r;
    endtask

    task automatic drive_audio();
        logic [31:0] r;
        r = rand_bits(16);
        ssp_audio_i <= r[15:0];
        r = rand_bits(21);
        {speaker_i, mb_audio_l_i, mb_audio_r_i} <= r[20:0];
    endtask

    // Short PHI1 pulses must not reach the bus direction
    task automatic phi_glitch(input int width);
        for (int i = 0; i < GLITCH_WATCH; i++) begin
            @(posedge clk_logic_w);
            a2_phi1_i <= (i < width);
            @(negedge clk_logic_w);
            if (a2_d_dir_o !== 1'b1) report_mismatch("phi glitch dir", 1, a2_d_dir_o);
        end
    endtask

    task automatic phi_hold(input logic level, input logic exp_dir);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        @(posedge clk_logic_w);
        a2_phi1_i <= level;
        while (!seen && n <= 7) begin
            @(negedge clk_logic_w);
            if (a2_d_dir_o === exp_dir) seen = 1'b1;
            else n++;
        end
        if (!seen) report_problem("bus direction did not follow a held PHI1 within 7 cycles");
        else if (n < 4) report_problem("bus direction followed PHI1 in under 4 cycles");
        repeat (HOLD_SETTLE) @(posedge clk_logic_w);
    endtask

    initial begin
        rst_i = 1'b1;
        a2_reset_n_i = 1'b1;
        a2_phi1_i = 1'b0;
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b001;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b011;
        {ssc_data_i, ssp_data_i, mb_data_i, a2_d_i} = 32'h11223344;
        ssp_audio_i = 16'h1234;
        mb_audio_l_i = 10'h155;
        mb_audio_r_i = 10'h2aa;
        speaker_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_logic_w);
        rst_i <= 1'b0;
        repeat (HB_CYCLES + 8) @(posedge clk_logic_w);
        phi_glitch(DENOISE_DEPTH - 2);
        phi_glitch(DENOISE_DEPTH - 1);
        phi_hold(1'b1, 1'b0);
        phi_hold(1'b0, 1'b1);
        repeat (ARB_CYCLES) begin
            @(posedge clk_logic_w);
            mode = MODE_ARB;
            drive_cards(1'b0);
        end
        repeat (MIX_CYCLES) begin
            @(posedge clk_logic_w);
            mode = MODE_NONE;
            drive_audio();
        end
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b0;
        repeat (BUSRST_CYCLES) begin
            @(posedge clk_logic_w);
            mode = MODE_BUSRST;
            drive_cards(1'b1);
        end
        @(posedge clk_logic_w);
        mode = MODE_NONE;
        a2_reset_n_i <= 1'b1;
        repeat (TAIL_CYCLES) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        if (frames_done < MIN_FRAMES) report_problem("too few complete status frames were seen");
        $display("Errors: %0d value mismatches, %0d other failures", mismatches, problems);
        if (mismatches + problems == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_logic_w);
        report_problem("watchdog expired before the test sequence ended");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Compare process on the falling edge, half a cycle after the inputs change
    always @(negedge clk_logic_w) begin
        if (rst_i) since_rel = 0;
        else since_rel++;
        if (since_rel <= HB_CYCLES) begin
            if (a2_d_dir_o !== 1'b0) report_mismatch("quiet dir", 0, a2_d_dir_o);
            if (a2_irq_n_o !== 1'b1) report_mismatch("quiet irq_n", 1, a2_irq_n_o);
            if (parl_frame_n_o !== 1'b1) report_mismatch("quiet frame_n", 1, parl_frame_n_o);
            if ({audio_l_o, audio_r_o} !== 32'h0) begin
                report_mismatch("quiet audio", 0, {audio_l_o, audio_r_o});
            end
        end
        // LED starts high and flips on every wrap of the heartbeat counter
        exp_led = (since_rel == 0) ? 1'b1 : (((since_rel - 1) / HB_CYCLES) % 2 == 0);
        if (led_n_o !== exp_led) report_mismatch("heartbeat led_n", exp_led, led_n_o);
        if (since_rel >= HB_CYCLES + 2) begin
            if (audio_l_o !== exp_l_q) report_mismatch("mix left", exp_l_q, audio_l_o);
            if (audio_r_o !== exp_r_q) report_mismatch("mix right", exp_r_q, audio_r_o);
        end
        exp_l_q = ref_mix(ssp_audio_i, mb_audio_l_i, speaker_i);
        exp_r_q = ref_mix(ssp_audio_i, mb_audio_r_i, speaker_i);
        if (mode != MODE_NONE) begin
            exp_bus = ref_bus(1'b1, mode == MODE_BUSRST, {mb_rd_i, ssp_rd_i, ssc_rd_i},
                              {mb_irq_n_i, ssp_irq_n_i, ssc_irq_n_i},
                              ssc_data_i, ssp_data_i, mb_data_i, a2_d_i);
            if (a2_d_dir_o !== exp_bus[9]) report_mismatch("bus dir", exp_bus[9], a2_d_dir_o);
            if (a2_irq_n_o !== exp_bus[8]) report_mismatch("bus irq_n", exp_bus[8], a2_irq_n_o);
            if (a2_d_o !== exp_bus[7:0]) report_mismatch("bus data", exp_bus[7:0], a2_d_o);
            if (mode == MODE_BUSRST && {parl_frame_n_o, parl_clk_o} !== 2'b10) begin
                report_mismatch("bus reset stream idle", 2'b10, {parl_frame_n_o, parl_clk_o});
            end
        end
        // A bus reset drops any stream frame in flight
        if (!a2_reset_n_i) begin
            in_frame = 1'b0;
            have_start = 1'b0;
        end else begin
            if (!parl_frame_n_o && prev_frame_n) begin
                if (have_start && since_rel - last_start != 2 ** SEND_LOG2) begin
                    report_mismatch("stream period", 2 ** SEND_LOG2, since_rel - last_start);
                end
                have_start = 1'b1;
                last_start = since_rel;
                in_frame = 1'b1;
                beats = 0;
                low_cycles = 0;
                frame_word = '0;
            end
            if (in_frame && !parl_frame_n_o) begin
                low_cycles++;
                if (parl_clk_o && !prev_clk) begin
                    if (beats < NIBBLES_PER_WORD && parl_d_o !== ref_nibble(beats)) begin
                        report_mismatch("stream nibble", ref_nibble(beats), parl_d_o);
                    end
                    frame_word = {frame_word[27:0], parl_d_o};
                    beats++;
                end
            end
            if (in_frame && parl_frame_n_o) begin
                in_frame = 1'b0;
                frames_done++;
                if (beats != NIBBLES_PER_WORD) begin
                    report_mismatch("stream beats", NIBBLES_PER_WORD, beats);
                end
                if (frame_word !== STATUS_WORD) begin
                    report_mismatch("stream word", STATUS_WORD, frame_word);
                end
                if (low_cycles != 2 * NIBBLES_PER_WORD) begin
                    report_mismatch("stream frame length", 2 * NIBBLES_PER_WORD, low_cycles);
                end
            end
        end
        prev_clk = parl_clk_o;
        prev_frame_n = parl_frame_n_o;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock source, free running square wave for the logic clock domain
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== verilog/a2_card_top.sv ====
// Card top level that connects the reset, PHI1 filter, bus arbiter, mixer and status stream
`timescale 1ns/1ps

module a2_card_top #(
    parameter int HEARTBEAT_CYCLES   = a2_bus_pkg::HEARTBEAT_CYCLES_DEFAULT,
    parameter int SEND_INTERVAL_LOG2 = a2_media_pkg::SEND_INTERVAL_LOG2_DEFAULT
) (
    input  logic                    clk_logic_w,
    input  logic                    rst_i,
    input  logic                    a2_reset_n_i,
    input  logic                    a2_phi1_i,

    // Apple II data bus and interrupt
    input  a2_bus_pkg::a2_data_t    a2_d_i,
    output a2_bus_pkg::a2_data_t    a2_d_o,
    output logic                    a2_d_dir_o,
    output logic                    a2_irq_n_o,

    // Card functions
    input  logic                    ssc_rd_i,
    input  logic                    ssp_rd_i,
    input  logic                    mb_rd_i,
    input  a2_bus_pkg::a2_data_t    ssc_data_i,
    input  a2_bus_pkg::a2_data_t    ssp_data_i,
    input  a2_bus_pkg::a2_data_t    mb_data_i,
    input  logic                    ssc_irq_n_i,
    input  logic                    ssp_irq_n_i,
    input  logic                    mb_irq_n_i,
    input  a2_media_pkg::sample_t   ssp_audio_i,
    input  a2_media_pkg::mb_level_t mb_audio_l_i,
    input  a2_media_pkg::mb_level_t mb_audio_r_i,
    input  logic                    speaker_i,

    // Audio out
    output a2_media_pkg::sample_t   audio_l_o,
    output a2_media_pkg::sample_t   audio_r_o,

    // Heartbeat and MCU link
    output logic                    led_n_o,
    output logic                    parl_clk_o,
    output logic                    parl_frame_n_o,
    output a2_media_pkg::nibble_t   parl_d_o
);

    logic device_rst_w;
    logic system_rst_w;
    logic phi0_w;

    reset_heartbeat #(
        .HEARTBEAT_CYCLES(HEARTBEAT_CYCLES)
    ) u_reset (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .a2_reset_n_i(a2_reset_n_i),
        .led_n_o     (led_n_o),
        .device_rst_o(device_rst_w),
        .system_rst_o(system_rst_w)
    );

    // Filtered PHI1, only the phi0 copy is needed here
    signal_denoise u_phi1 (
        .clk_logic_w(clk_logic_w),
        .rst_i      (rst_i),
        .sig_i      (a2_phi1_i),
        .sig_o      (),
        .sig_n_o    (phi0_w),
        .posedge_o  (),
        .negedge_o  ()
    );

    bus_drive_arbiter u_arbiter (
        .clk_logic_w (clk_logic_w),
        .system_rst_i(system_rst_w),
        .phi0_i      (phi0_w),
        .ssc_rd_i    (ssc_rd_i),
        .ssp_rd_i    (ssp_rd_i),
        .mb_rd_i     (mb_rd_i),
        .ssc_data_i  (ssc_data_i),
        .ssp_data_i  (ssp_data_i),
        .mb_data_i   (mb_data_i),
        .bus_data_i  (a2_d_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .a2_d_dir_o  (a2_d_dir_o),
        .a2_d_o      (a2_d_o),
        .a2_irq_n_o  (a2_irq_n_o)
    );

    audio_mixer u_mixer (
        .clk_logic_w (clk_logic_w),
        .device_rst_i(device_rst_w),
        .ssp_audio_i (ssp_audio_i),
        .mb_audio_l_i(mb_audio_l_i),
        .mb_audio_r_i(mb_audio_r_i),
        .speaker_i   (speaker_i),
        .audio_l_o   (audio_l_o),
        .audio_r_o   (audio_r_o)
    );

    qspi_status_streamer #(
        .SEND_INTERVAL_LOG2(SEND_INTERVAL_LOG2)
    ) u_streamer (
        .clk_logic_w   (clk_logic_w),
        .system_rst_i  (system_rst_w),
        .parl_clk_o    (parl_clk_o),
        .parl_frame_n_o(parl_frame_n_o),
        .parl_d_o      (parl_d_o)
    );

endmodule

// ==== verilog/qspi_status_streamer.sv ====
// Sends the status word to the companion MCU as periodic 4-bit QSPI frames
`timescale 1ns/1ps

module qspi_status_streamer #(
    parameter int SEND_INTERVAL_LOG2 = a2_media_pkg::SEND_INTERVAL_LOG2_DEFAULT
) (
    input  logic                  clk_logic_w,
    input  logic                  system_rst_i,
    output logic                  parl_clk_o,
    output logic                  parl_frame_n_o,
    output a2_media_pkg::nibble_t parl_d_o
);

    import a2_media_pkg::*;

    localparam int NIB_W = $clog2(NIBBLES_PER_WORD);

    logic [SEND_INTERVAL_LOG2-1:0] interval_r;
    logic                          strobe_w;
    qspi_state_t                   state_r;
    logic [NIB_W-1:0]              nib_cnt_r;
    logic                          phase_r;
    status_word_t                  shift_r;
    logic                          clk_r;
    logic                          frame_n_r;

    // Free running frame timer
    always_ff @(posedge clk_logic_w) begin
        if (system_rst_i) begin
            interval_r <= '0;
        end else begin
            interval_r <= interval_r + 1'b1;
        end
    end

    assign strobe_w = (interval_r == '0);

    always_ff @(posedge clk_logic_w) begin
        if (system_rst_i) begin
            state_r   <= IDLE;
            nib_cnt_r <= '0;
            phase_r   <= 1'b0;
            shift_r   <= '0;
            clk_r     <= 1'b0;
            frame_n_r <= 1'b1;
        end else begin
            case (state_r)
                IDLE: begin
                    if (strobe_w) begin
                        state_r   <= SHIFT;
                        nib_cnt_r <= '0;
                        phase_r   <= 1'b0;
                        shift_r   <= STATUS_WORD;
                        clk_r     <= 1'b0;
                        frame_n_r <= 1'b0;
                    end
                end
                SHIFT: begin
                    if (!phase_r) begin
                        // Receiver samples on this rising edge
                        clk_r   <= 1'b1;
                        phase_r <= 1'b1;
                    end else begin
                        clk_r   <= 1'b0;
                        phase_r <= 1'b0;
                        // Last shift leaves the data lines at zero
                        shift_r <= shift_r << 4;
                        if (nib_cnt_r == NIB_W'(NIBBLES_PER_WORD - 1)) begin
                            state_r   <= IDLE;
                            frame_n_r <= 1'b1;
                        end else begin
                            nib_cnt_r <= nib_cnt_r + 1'b1;
                        end
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    assign parl_clk_o     = clk_r;
    assign parl_frame_n_o = frame_n_r;
    assign parl_d_o       = shift_r[31:28];

endmodule

// ==== verilog/audio_mixer.sv ====
// Sums the sprite, sound board and speaker audio into registered 16-bit stereo samples
`timescale 1ns/1ps

module audio_mixer (
    input  logic                    clk_logic_w,
    input  logic                    device_rst_i,
    input  a2_media_pkg::sample_t   ssp_audio_i,
    input  a2_media_pkg::mb_level_t mb_audio_l_i,
    input  a2_media_pkg::mb_level_t mb_audio_r_i,
    input  logic                    speaker_i,
    output a2_media_pkg::sample_t   audio_l_o,
    output a2_media_pkg::sample_t   audio_r_o
);

    import a2_media_pkg::*;

    sample_t audio_l_r;
    sample_t audio_r_r;

    // One channel, wraps modulo 2^16
    function automatic sample_t mix(input sample_t ssp, input mb_level_t mb, input logic spk);
        sample_t mb_term;
        sample_t spk_term;
        mb_term  = sample_t'(mb) << MB_SHIFT;
        spk_term = sample_t'(spk) << SPEAKER_SHIFT;
        return ssp + mb_term + spk_term;
    endfunction

    always_ff @(posedge clk_logic_w) begin
        if (device_rst_i) begin
            audio_l_r <= '0;
            audio_r_r <= '0;
        end else begin
            audio_l_r <= mix(ssp_audio_i, mb_audio_l_i, speaker_i);
            audio_r_r <= mix(ssp_audio_i, mb_audio_r_i, speaker_i);
        end
    end

    assign audio_l_o = audio_l_r;
    assign audio_r_o = audio_r_r;

endmodule

// ==== verilog/bus_drive_arbiter.sv ====
// Picks the card that drives the Apple II data bus and merges the card interrupts
`timescale 1ns/1ps

module bus_drive_arbiter (
    input  logic                  clk_logic_w,
    input  logic                  system_rst_i,
    input  logic                  phi0_i,
    input  logic                  ssc_rd_i,
    input  logic                  ssp_rd_i,
    input  logic                  mb_rd_i,
    input  a2_bus_pkg::a2_data_t  ssc_data_i,
    input  a2_bus_pkg::a2_data_t  ssp_data_i,
    input  a2_bus_pkg::a2_data_t  mb_data_i,
    input  a2_bus_pkg::a2_data_t  bus_data_i,
    input  logic                  ssc_irq_n_i,
    input  logic                  ssp_irq_n_i,
    input  logic                  mb_irq_n_i,
    output logic                  a2_d_dir_o,
    output a2_bus_pkg::a2_data_t  a2_d_o,
    output logic                  a2_irq_n_o
);

    import a2_bus_pkg::*;

    logic any_rd_w;
    logic irq_n_w;

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // Transceiver points at the bus only while phi0 is high
    assign a2_d_dir_o = phi0_i & any_rd_w & BUS_DATA_OUT_ENABLE & ~system_rst_i;

    // Serial card first, then sprite, then sound board
    always_comb begin
        if (ssc_rd_i) begin
            a2_d_o = ssc_data_i;
        end else if (ssp_rd_i) begin
            a2_d_o = ssp_data_i;
        end else if (mb_rd_i) begin
            a2_d_o = mb_data_i;
        end else begin
            a2_d_o = bus_data_i;
        end
    end

    // Active low, any card pulls the line
    assign irq_n_w    = ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i;
    assign a2_irq_n_o = (system_rst_i || !IRQ_OUT_ENABLE) ? 1'b1 : irq_n_w;

endmodule

// ==== verilog/reset_heartbeat.sv ====
// Heartbeat LED counter that also holds device reset and merges the bus reset pin
`timescale 1ns/1ps

module reset_heartbeat #(
    parameter int HEARTBEAT_CYCLES = a2_bus_pkg::HEARTBEAT_CYCLES_DEFAULT
) (
    input  logic clk_logic_w,
    input  logic rst_i,
    input  logic a2_reset_n_i,
    output logic led_n_o,
    output logic device_rst_o,
    output logic system_rst_o
);

    localparam int CNT_W = (HEARTBEAT_CYCLES > 1) ? $clog2(HEARTBEAT_CYCLES) : 1;

    logic [CNT_W-1:0] count_r;
    logic             wrap_w;
    logic             led_n_r;
    logic             ready_r;

    assign wrap_w = (count_r == CNT_W'(HEARTBEAT_CYCLES - 1));

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            count_r <= '0;
            led_n_r <= 1'b1;
            ready_r <= 1'b0;
        end else if (wrap_w) begin
            count_r <= '0;
            led_n_r <= ~led_n_r;
            // Sticky, the first wrap ends device reset
            ready_r <= 1'b1;
        end else begin
            count_r <= count_r + 1'b1;
        end
    end

    assign led_n_o      = led_n_r;
    assign device_rst_o = ~ready_r;

    // Bus reset pin passes straight through
    assign system_rst_o = ~ready_r | ~a2_reset_n_i;

endmodule

// ==== verilog/signal_denoise.sv ====
// Brings one asynchronous bus clock into the logic domain, filters glitches and flags its edges
`timescale 1ns/1ps

module signal_denoise (
    input  logic clk_logic_w,
    input  logic rst_i,
    input  logic sig_i,
    output logic sig_o,
    output logic sig_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    import a2_bus_pkg::*;

    logic                     sync1_r;
    logic                     sync2_r;
    logic [DENOISE_DEPTH-1:0] hist_r;
    logic                     sig_r;
    logic                     sig_n_r;
    logic                     pos_r;
    logic                     neg_r;
    logic                     all_high_w;
    logic                     all_low_w;

    // Level only moves once the whole window agrees
    assign all_high_w = &hist_r;
    assign all_low_w  = ~|hist_r;

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            sync1_r <= 1'b0;
            sync2_r <= 1'b0;
            hist_r  <= '0;
            sig_r   <= 1'b0;
            sig_n_r <= 1'b1;
            pos_r   <= 1'b0;
            neg_r   <= 1'b0;
        end else begin
            // Two-flop synchronizer ahead of the history window
            sync1_r <= sig_i;
            sync2_r <= sync1_r;
            hist_r  <= {hist_r[DENOISE_DEPTH-2:0], sync2_r};

            pos_r <= 1'b0;
            neg_r <= 1'b0;
            if (all_high_w && !sig_r) begin
                sig_r   <= 1'b1;
                sig_n_r <= 1'b0;
                pos_r   <= 1'b1;
            end else if (all_low_w && sig_r) begin
                sig_r   <= 1'b0;
                sig_n_r <= 1'b1;
                neg_r   <= 1'b1;
            end
        end
    end

    assign sig_o     = sig_r;
    assign sig_n_o   = sig_n_r;
    assign posedge_o = pos_r;
    assign negedge_o = neg_r;

endmodule

// ==== verilog/a2_media_pkg.sv ====
// Audio sample and QSPI status stream definitions shared by the mixer and the streamer
package a2_media_pkg;

    // Audio
    typedef logic [15:0] sample_t;
    typedef logic [9:0]  mb_level_t;

    // Sound board level sits just under the top bits of the sample
    localparam int MB_SHIFT      = 5;
    localparam int SPEAKER_SHIFT = 13;

    // Status stream to the companion microcontroller
    typedef logic [3:0]  nibble_t;
    typedef logic [31:0] status_word_t;

    localparam status_word_t STATUS_WORD = 32'h1234_5678;
    localparam int NIBBLES_PER_WORD = 8;
    localparam int SEND_INTERVAL_LOG2_DEFAULT = 20;

    typedef enum logic {
        IDLE,
        SHIFT
    } qspi_state_t;

endpackage

// ==== verilog/a2_bus_pkg.sv ====
// Bus-side widths, drive enables and timing constants shared by the card glue logic
package a2_bus_pkg;

    // One byte on the Apple II data bus
    typedef logic [7:0] a2_data_t;

    // Allow driving the Apple II interrupt line
    localparam bit IRQ_OUT_ENABLE = 1'b1;

    // Allow driving the Apple II data bus
    localparam bit BUS_DATA_OUT_ENABLE = 1'b1;

    // Equal samples needed before a filtered bus clock may change
    localparam int DENOISE_DEPTH = 3;

    // Heartbeat half period in logic clock cycles, 0.5 s at 20 MHz
    localparam int HEARTBEAT_CYCLES_DEFAULT = 10_000_000;

endpackage
